// File: logic/xalu.sv
`timescale 1ns/1ps

module xalu (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     en,
   input  xconf_pkg::lane_conf_t    lane_conf,
   input  xconf_pkg::data_t         in_a,
   input  xconf_pkg::data_t         in_b,
   input  xconf_pkg::data_t         alu0,
   input  xconf_pkg::data_t         konst,
   output xconf_pkg::data_t         result
);

   xconf_pkg::alu_op_t op;
   xconf_pkg::sel_t    sel_a;
   xconf_pkg::sel_t    sel_b;
   xconf_pkg::data_t   opa;
   xconf_pkg::data_t   opb;
   xconf_pkg::data_t   res_d;
   xconf_pkg::data_t   res_q;

   // operand mux shared by both ALU inputs
   function automatic xconf_pkg::data_t pick(input xconf_pkg::sel_t  sel,
                                             input xconf_pkg::data_t a,
                                             input xconf_pkg::data_t b,
                                             input xconf_pkg::data_t r0,
                                             input xconf_pkg::data_t k);
      case (sel)
         xconf_pkg::SEL_IN_A: pick = a;
         xconf_pkg::SEL_IN_B: pick = b;
         xconf_pkg::SEL_ALU0: pick = r0;
         default:             pick = k;
      endcase
   endfunction

   assign op    = lane_conf[xconf_pkg::LANE_OP_LSB +: 3];
   assign sel_a = lane_conf[xconf_pkg::LANE_SELA_LSB +: 2];
   assign sel_b = lane_conf[xconf_pkg::LANE_SELB_LSB +: 2];

   assign opa = pick(sel_a, in_a, in_b, alu0, konst);
   assign opb = pick(sel_b, in_a, in_b, alu0, konst);

   // results wrap modulo 2^16 and max and min compare unsigned
   always_comb begin
      case (op)
         xconf_pkg::ALU_ADD: res_d = opa + opb;
         xconf_pkg::ALU_SUB: res_d = opa - opb;
         xconf_pkg::ALU_AND: res_d = opa & opb;
         xconf_pkg::ALU_OR:  res_d = opa | opb;
         xconf_pkg::ALU_XOR: res_d = opa ^ opb;
         xconf_pkg::ALU_MAX: res_d = (opa > opb) ? opa : opb;
         xconf_pkg::ALU_MIN: res_d = (opa < opb) ? opa : opb;
         default:            res_d = opa;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         res_q <= '0;
      end else if (en) begin
         res_q <= res_d;
      end
   end

   assign result = res_q;

endmodule

// File: logic/xconf.sv
`timescale 1ns/1ps

module xconf #(
   parameter int CONF_MEM_SLOTS = 8
) (
   input  logic                   clk,
   input  logic                   rst_n,

   // control bus
   input  logic                   ctr_req,
   input  logic                   ctr_rnw,
   input  xconf_pkg::ctr_addr_t   ctr_addr,
   input  xconf_pkg::data_t       ctr_data,

   output xconf_pkg::conf_t       conf_out,
   output logic                   bus_err
);

   logic                              reg_wr;
   logic                              mem_req;
   logic                              bad_req;
   logic                              err_q;
   logic [xconf_pkg::MEM_SLOT_W-1:0]  mem_slot;
   logic                              conf_ld;
   xconf_pkg::conf_t                  conf_from_mem;

   assign mem_slot = xconf_pkg::MEM_SLOT_W'(ctr_addr - xconf_pkg::CONF_MEM_BASE);

   // address decode, only writes reach the register fields
   always_comb begin
      reg_wr  = 1'b0;
      mem_req = 1'b0;
      if (ctr_addr < xconf_pkg::CONF_REG_OFFSET) begin
         reg_wr = ctr_req && !ctr_rnw && (ctr_addr[1:0] <= xconf_pkg::FLD_CONST);
      end else if (ctr_addr >= xconf_pkg::CONF_MEM_BASE) begin
         mem_req = ctr_req && (int'(mem_slot) < CONF_MEM_SLOTS);
      end
   end

   assign bad_req = ctr_req && !reg_wr && !mem_req;

   // one-cycle error pulse after a bad strobe
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         err_q <= 1'b0;
      end else begin
         err_q <= bad_req;
      end
   end

   assign bus_err = err_q;

   xconf_reg u_reg (
      .clk      (clk),
      .rst_n    (rst_n),
      .wr       (reg_wr),
      .addr     (ctr_addr[1:0]),
      .data_in  (ctr_data),
      .conf_ld  (conf_ld),
      .conf_in  (conf_from_mem),
      .conf_out (conf_out)
   );

   xconf_mem #(
      .CONF_MEM_SLOTS (CONF_MEM_SLOTS)
   ) u_mem (
      .clk      (clk),
      .rst_n    (rst_n),
      .req      (mem_req),
      .rnw      (ctr_rnw),
      .slot     (mem_slot),
      .conf_in  (conf_out),
      .conf_out (conf_from_mem),
      .conf_ld  (conf_ld)
   );

   a_one_target: assert property (
      @(posedge clk) disable iff (!rst_n)
      !(reg_wr && mem_req)
   ) else $error("xconf: register write and memory request in same cycle");

endmodule

// File: logic/xconf_mem.sv
`timescale 1ns/1ps

module xconf_mem #(
   parameter int CONF_MEM_SLOTS = 8
) (
   input  logic                                clk,
   input  logic                                rst_n,
   input  logic                                req,
   input  logic                                rnw,
   input  logic [xconf_pkg::MEM_SLOT_W-1:0]    slot,
   input  xconf_pkg::conf_t                    conf_in,
   output xconf_pkg::conf_t                    conf_out,
   output logic                                conf_ld
);

   xconf_pkg::conf_t mem [CONF_MEM_SLOTS];
   xconf_pkg::conf_t rd_q;
   logic             ld_q;

   // store snapshots of the live config word
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < CONF_MEM_SLOTS; i++) begin
            mem[i] <= '0;
         end
      end else if (req && !rnw) begin
         mem[slot] <= conf_in;
      end
   end

   // load request, data and strobe land together next cycle
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ld_q <= 1'b0;
      end else begin
         ld_q <= req && rnw;
      end
   end

   always_ff @(posedge clk) begin
      if (req && rnw) begin
         rd_q <= mem[slot];
      end
   end

   assign conf_out = rd_q;
   assign conf_ld  = ld_q;

   // decoder must filter slots beyond the configured depth
   a_slot_range: assert property (
      @(posedge clk) disable iff (!rst_n)
      req |-> (int'(slot) < CONF_MEM_SLOTS)
   ) else $error("xconf_mem: slot %0d out of range", slot);

endmodule

// File: logic/xconf_pkg.sv
package xconf_pkg;

   // datapath width
   localparam int DATA_W = 16;

   typedef logic [DATA_W-1:0] data_t;
   typedef logic [3:0]        ctr_addr_t;
   typedef logic [2:0]        alu_op_t;
   typedef logic [1:0]        sel_t;

   // lane config is {op, sel_a, sel_b}
   localparam int LANE_CONF_W   = 7;
   localparam int LANE_OP_LSB   = 4;
   localparam int LANE_SELA_LSB = 2;
   localparam int LANE_SELB_LSB = 0;

   typedef logic [LANE_CONF_W-1:0] lane_conf_t;

   // config word is {lane0, lane1, constant}
   localparam int CONF_BITS     = 2 * LANE_CONF_W + DATA_W;
   localparam int CONF_CONST_LSB = 0;
   localparam int CONF_ALU1_LSB  = DATA_W;
   localparam int CONF_ALU0_LSB  = DATA_W + LANE_CONF_W;

   typedef logic [CONF_BITS-1:0] conf_t;

   // control bus address map
   localparam logic [1:0] FLD_ALU0        = 2'd0;
   localparam logic [1:0] FLD_ALU1        = 2'd1;
   localparam logic [1:0] FLD_CONST       = 2'd2;
   localparam ctr_addr_t  CONF_REG_OFFSET = 4'd4;
   localparam ctr_addr_t  CONF_MEM_BASE   = 4'd8;
   localparam int         MEM_SLOT_W      = 3;

   // opcodes
   localparam alu_op_t ALU_ADD  = 3'd0;
   localparam alu_op_t ALU_SUB  = 3'd1;
   localparam alu_op_t ALU_AND  = 3'd2;
   localparam alu_op_t ALU_OR   = 3'd3;
   localparam alu_op_t ALU_XOR  = 3'd4;
   localparam alu_op_t ALU_MAX  = 3'd5;
   localparam alu_op_t ALU_MIN  = 3'd6;
   localparam alu_op_t ALU_PASS = 3'd7;

   // operand selects
   localparam sel_t SEL_IN_A  = 2'd0;
   localparam sel_t SEL_IN_B  = 2'd1;
   localparam sel_t SEL_ALU0  = 2'd2;
   localparam sel_t SEL_CONST = 2'd3;

endpackage

// File: logic/xconf_reg.sv
`timescale 1ns/1ps

module xconf_reg (
   input  logic                clk,
   input  logic                rst_n,

   // field write from the bus decoder
   input  logic                wr,
   input  logic [1:0]          addr,
   input  xconf_pkg::data_t    data_in,

   // whole-word load from snapshot memory
   input  logic                conf_ld,
   input  xconf_pkg::conf_t    conf_in,

   output xconf_pkg::conf_t    conf_out
);

   xconf_pkg::conf_t conf_q;

   // load from memory has priority over a field write
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         conf_q <= '0;
      end else if (conf_ld) begin
         conf_q <= conf_in;
      end else if (wr) begin
         case (addr)
            xconf_pkg::FLD_ALU0: begin
               conf_q[xconf_pkg::CONF_ALU0_LSB +: xconf_pkg::LANE_CONF_W] <=
                  xconf_pkg::lane_conf_t'(data_in);
            end
            xconf_pkg::FLD_ALU1: begin
               conf_q[xconf_pkg::CONF_ALU1_LSB +: xconf_pkg::LANE_CONF_W] <=
                  xconf_pkg::lane_conf_t'(data_in);
            end
            xconf_pkg::FLD_CONST: begin
               conf_q[xconf_pkg::CONF_CONST_LSB +: xconf_pkg::DATA_W] <= data_in;
            end
            default: begin
               conf_q <= conf_q;
            end
         endcase
      end
   end

   assign conf_out = conf_q;

   // the decoder only forwards writes to the three mapped fields
   a_no_fld3_wr: assert property (
      @(posedge clk) disable iff (!rst_n)
      wr |-> (addr != 2'd3)
   ) else $error("xconf_reg: write to reserved field index 3");

endmodule

// File: logic/xdata_eng.sv
`timescale 1ns/1ps

module xdata_eng (
   input  logic                clk,
   input  logic                rst_n,
   input  xconf_pkg::conf_t    conf,

   // operand stream in
   input  logic                in_valid,
   input  xconf_pkg::data_t    in_a,
   input  xconf_pkg::data_t    in_b,

   // result stream out
   output logic                out_valid,
   output xconf_pkg::data_t    out_data
);

   xconf_pkg::lane_conf_t lane0_conf;
   xconf_pkg::lane_conf_t lane1_conf;
   xconf_pkg::data_t      konst;

   logic                  valid_s1;
   logic                  valid_s2;
   xconf_pkg::data_t      a_s1;
   xconf_pkg::data_t      b_s1;
   xconf_pkg::data_t      alu0_res;
   xconf_pkg::data_t      alu1_res;

   // split the configuration word
   assign lane0_conf = conf[xconf_pkg::CONF_ALU0_LSB +: xconf_pkg::LANE_CONF_W];
   assign lane1_conf = conf[xconf_pkg::CONF_ALU1_LSB +: xconf_pkg::LANE_CONF_W];
   assign konst      = conf[xconf_pkg::CONF_CONST_LSB +: xconf_pkg::DATA_W];

   // two-stage valid pipe
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         valid_s1 <= 1'b0;
         valid_s2 <= 1'b0;
      end else begin
         valid_s1 <= in_valid;
         valid_s2 <= valid_s1;
      end
   end

   // operands held one cycle for lane 1
   always_ff @(posedge clk) begin
      if (in_valid) begin
         a_s1 <= in_a;
         b_s1 <= in_b;
      end
   end

   // lane 0 has no upstream ALU
   xalu u_alu0 (
      .clk       (clk),
      .rst_n     (rst_n),
      .en        (in_valid),
      .lane_conf (lane0_conf),
      .in_a      (in_a),
      .in_b      (in_b),
      .alu0      ('0),
      .konst     (konst),
      .result    (alu0_res)
   );

   xalu u_alu1 (
      .clk       (clk),
      .rst_n     (rst_n),
      .en        (valid_s1),
      .lane_conf (lane1_conf),
      .in_a      (a_s1),
      .in_b      (b_s1),
      .alu0      (alu0_res),
      .konst     (konst),
      .result    (alu1_res)
   );

   assign out_valid = valid_s2;
   assign out_data  = alu1_res;

   // fixed two-cycle latency, both directions
   a_lat_fwd: assert property (
      @(posedge clk) disable iff (!rst_n)
      in_valid |-> ##2 out_valid
   ) else $error("xdata_eng: result missing two cycles after input");

   a_lat_bwd: assert property (
      @(posedge clk) disable iff (!rst_n)
      out_valid |-> $past(in_valid, 2)
   ) else $error("xdata_eng: result without matching input");

endmodule

// File: logic/xversat_top.sv
`timescale 1ns/1ps

module xversat_top #(
   parameter int CONF_MEM_SLOTS = 8
) (
   input  logic                   clk,
   input  logic                   rst_n,

   // control bus
   input  logic                   ctr_req,
   input  logic                   ctr_rnw,
   input  xconf_pkg::ctr_addr_t   ctr_addr,
   input  xconf_pkg::data_t       ctr_data,
   output logic                   bus_err,

   // operand and result streams
   input  logic                   in_valid,
   input  xconf_pkg::data_t       in_a,
   input  xconf_pkg::data_t       in_b,
   output logic                   out_valid,
   output xconf_pkg::data_t       out_data
);

   xconf_pkg::conf_t conf_out;

   xconf #(
      .CONF_MEM_SLOTS (CONF_MEM_SLOTS)
   ) u_conf (
      .clk      (clk),
      .rst_n    (rst_n),
      .ctr_req  (ctr_req),
      .ctr_rnw  (ctr_rnw),
      .ctr_addr (ctr_addr),
      .ctr_data (ctr_data),
      .conf_out (conf_out),
      .bus_err  (bus_err)
   );

   xdata_eng u_eng (
      .clk       (clk),
      .rst_n     (rst_n),
      .conf      (conf_out),
      .in_valid  (in_valid),
      .in_a      (in_a),
      .in_b      (in_b),
      .out_valid (out_valid),
      .out_data  (out_data)
   );

endmodule

// File: sim/xversat_model.svh
`ifndef XVERSAT_MODEL_SVH
`define XVERSAT_MODEL_SVH

// config word layout: [29:23] lane 0, [22:16] lane 1, [15:0] constant
// lane layout: [6:4] opcode, [3:2] select a, [1:0] select b
logic [29:0] model_conf;
logic [29:0] model_mem [8];

// expected results with the cycle they are due
int          due_q [$];
logic [15:0] val_q [$];

function automatic void model_clear();
   model_conf = '0;
   for (int i = 0; i < 8; i++) begin
      model_mem[i] = '0;
   end
   due_q.delete();
   val_q.delete();
endfunction

function automatic logic [15:0] model_pick(input logic [1:0] sel, input logic [15:0] a,
                                           input logic [15:0] b, input logic [15:0] alu0,
                                           input logic [15:0] konst);
   case (sel)
      2'd0:    return a;
      2'd1:    return b;
      2'd2:    return alu0;
      default: return konst;
   endcase
endfunction

function automatic logic [15:0] model_lane(input logic [6:0] lane, input logic [15:0] a,
                                           input logic [15:0] b, input logic [15:0] alu0,
                                           input logic [15:0] konst);
   logic [15:0] x;
   logic [15:0] y;
   x = model_pick(lane[3:2], a, b, alu0, konst);
   y = model_pick(lane[1:0], a, b, alu0, konst);
   case (lane[6:4])
      3'd0:    return x + y;
      3'd1:    return x - y;
      3'd2:    return x & y;
      3'd3:    return x | y;
      3'd4:    return x ^ y;
      3'd5:    return (x > y) ? x : y;
      3'd6:    return (x < y) ? x : y;
      default: return x;
   endcase
endfunction

// lane 1 sees the same operands plus the lane 0 result
function automatic logic [15:0] model_result(input logic [29:0] conf, input logic [15:0] a,
                                             input logic [15:0] b);
   logic [15:0] r0;
   r0 = model_lane(conf[29:23], a, b, 16'h0000, conf[15:0]);
   return model_lane(conf[22:16], a, b, r0, conf[15:0]);
endfunction

// applies one bus strobe, returns 1 for an unmapped access
function automatic logic model_bus_access(input logic rnw, input logic [3:0] addr,
                                          input logic [15:0] data, input int slots);
   int slot;
   slot = int'(addr) - 8;
   if (addr <= 4'd2) begin
      if (rnw) begin
         return 1'b1;
      end
      case (addr)
         4'd0:    model_conf[29:23] = data[6:0];
         4'd1:    model_conf[22:16] = data[6:0];
         default: model_conf[15:0] = data;
      endcase
      return 1'b0;
   end
   if (slot >= 0 && slot < slots) begin
      if (rnw) begin
         model_conf = model_mem[slot];
      end else begin
         model_mem[slot] = model_conf;
      end
      return 1'b0;
   end
   return 1'b1;
endfunction

`endif

// File: sim/tb_xversat.sv
`timescale 1ns/1ps

module tb_xversat;

   localparam int MEM_SLOTS   = 8;
   // planned test length with margin, doubled for the timeout
   localparam int TEST_CYCLES = 2000;
   localparam int MAX_CYCLES  = 2 * TEST_CYCLES;

   logic        clk;
   logic        rst_n;
   logic        ctr_req;
   logic        ctr_rnw;
   logic [3:0]  ctr_addr;
   logic [15:0] ctr_data;
   logic        bus_err;
   logic        in_valid;
   logic [15:0] in_a;
   logic [15:0] in_b;
   logic        out_valid;
   logic [15:0] out_data;

   int   cycle      = 0;
   int   run_cycles = 0;
   logic err_exp    = 1'b0;
   int   order [MEM_SLOTS];

   `include "xversat_model.svh"

   xversat_top #(
      .CONF_MEM_SLOTS (MEM_SLOTS)
   ) u_dut (
      .clk       (clk),
      .rst_n     (rst_n),
      .ctr_req   (ctr_req),
      .ctr_rnw   (ctr_rnw),
      .ctr_addr  (ctr_addr),
      .ctr_data  (ctr_data),
      .bus_err   (bus_err),
      .in_valid  (in_valid),
      .in_a      (in_a),
      .in_b      (in_b),
      .out_valid (out_valid),
      .out_data  (out_data)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   always @(posedge clk) begin
      run_cycles <= run_cycles + 1;
      if (run_cycles >= MAX_CYCLES) begin
         $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
         $display("TB FAILED");
         $fatal(1, "simulation stopped by timeout");
      end
   end

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         $display("MISMATCH t=%0t %s got=%h exp=%h", $time, name, got, exp);
         $display("TB FAILED");
         $fatal(1, "value check failed");
      end
   endtask

   // one cycle: check outputs on the falling edge, then drive the next inputs
   task automatic step(input logic req, input logic rnw, input logic [3:0] addr,
                       input logic [15:0] data, input logic valid,
                       input logic [15:0] a, input logic [15:0] b);
      logic exp_valid;
      @(negedge clk);
      cycle++;
      exp_valid = (due_q.size() > 0) && (due_q[0] == cycle);
      check_value("bus_err", bus_err, err_exp);
      check_value("out_valid", out_valid, exp_valid);
      if (exp_valid) begin
         check_value("out_data", out_data, val_q[0]);
         void'(due_q.pop_front());
         void'(val_q.pop_front());
      end
      ctr_req  = req;
      ctr_rnw  = rnw;
      ctr_addr = addr;
      ctr_data = data;
      in_valid = valid;
      in_a     = a;
      in_b     = b;
      if (valid) begin
         due_q.push_back(cycle + 2);
         val_q.push_back(model_result(model_conf, a, b));
      end
      err_exp = req ? model_bus_access(rnw, addr, data, MEM_SLOTS) : 1'b0;
   endtask

   task automatic idle(input int n);
      repeat (n) step(1'b0, 1'b0, 4'd0, 16'h0, 1'b0, 16'h0, 16'h0);
   endtask

   // engine stays quiet around every config change
   task automatic bus_access(input logic rnw, input logic [3:0] addr, input logic [15:0] data);
      idle(3);
      step(1'b1, rnw, addr, data, 1'b0, 16'h0, 16'h0);
      idle(3);
   endtask

   task automatic stream(input int n, input bit always_valid);
      logic valid;
      repeat (n) begin
         valid = always_valid ? 1'b1 : 1'($urandom_range(1, 0));
         step(1'b0, 1'b0, 4'd0, 16'h0, valid, 16'($urandom()), 16'($urandom()));
      end
   endtask

   // lane 0 never selects the lane 0 result
   function automatic logic [6:0] random_lane(input bit lane0);
      logic [1:0] sa;
      logic [1:0] sb;
      sa = 2'($urandom_range(3, 0));
      sb = 2'($urandom_range(3, 0));
      if (lane0 && sa == 2'd2) sa = 2'd3;
      if (lane0 && sb == 2'd2) sb = 2'd0;
      return {3'($urandom_range(7, 0)), sa, sb};
   endfunction

   task automatic write_field(input int field);
      logic [15:0] data;
      data = 16'($urandom());
      if (field < 2) begin
         data[6:0] = random_lane(field == 0);
      end
      bus_access(1'b0, 4'(field), data);
   endtask

   task automatic shuffle_slots();
      int j;
      int t;
      for (int i = 0; i < MEM_SLOTS; i++) begin
         order[i] = i;
      end
      for (int i = MEM_SLOTS - 1; i > 0; i--) begin
         j = $urandom_range(i, 0);
         t = order[i];
         order[i] = order[j];
         order[j] = t;
      end
   endtask

   initial begin
      logic [3:0] bad_addr;
      logic       bad_rnw;
      void'($urandom(32'h49b7_663e));
      rst_n    = 1'b0;
      ctr_req  = 1'b0;
      ctr_rnw  = 1'b0;
      ctr_addr = 4'd0;
      ctr_data = 16'h0;
      in_valid = 1'b0;
      in_a     = 16'h0;
      in_b     = 16'h0;
      model_clear();
      repeat (5) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      // zeroed config doubles operand a
      stream(40, 1'b1);

      repeat (40) begin
         write_field($urandom_range(2, 0));
         stream(8, 1'b1);
      end

      // random valid gaps, a fresh config each round
      repeat (4) begin
         for (int f = 0; f < 3; f++) begin
            write_field(f);
         end
         stream(50, 1'b0);
      end

      // snapshots stored in one order, reloaded in reverse
      shuffle_slots();
      for (int i = 0; i < MEM_SLOTS; i++) begin
         for (int f = 0; f < 3; f++) begin
            write_field(f);
         end
         bus_access(1'b0, 4'(8 + order[i]), 16'($urandom()));
      end
      for (int f = 0; f < 3; f++) begin
         write_field(f);
      end
      for (int i = MEM_SLOTS - 1; i >= 0; i--) begin
         bus_access(1'b1, 4'(8 + order[i]), 16'($urandom()));
         stream(10, 1'b0);
      end

      // unmapped addresses and register reads
      repeat (60) begin
         if ($urandom_range(1, 0)) begin
            bad_addr = 4'($urandom_range(7, 3));
            bad_rnw  = 1'($urandom_range(1, 0));
         end else begin
            bad_addr = 4'($urandom_range(2, 0));
            bad_rnw  = 1'b1;
         end
         step(1'b1, bad_rnw, bad_addr, 16'($urandom()), 1'($urandom_range(1, 0)),
              16'($urandom()), 16'($urandom()));
      end
      idle(4);

      if (due_q.size() != 0) begin
         $display("expected results still pending at end of run: %0d", due_q.size());
         $display("TB FAILED");
         $fatal(1, "results missing");
      end else begin
         $display("TB PASSED");
         $finish;
      end
   end

endmodule

// File: xversat.f
+incdir+sim
logic/xconf_pkg.sv
logic/xconf_reg.sv
logic/xconf_mem.sv
logic/xconf.sv
logic/xalu.sv
logic/xdata_eng.sv
logic/xversat_top.sv
sim/tb_xversat.sv
